// ==== Makefile ====
# build the testbench with verilator, run it, and check the log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_sdp_rdma_ig -o tb_sim
	./obj_dir/tb_sim +verilator+error+limit+1000 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "simulation ended early"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module tb_sdp_rdma_ig

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
+incdir+.
sdp_rdma_cfg_pkg.sv
sdp_rdma_req_pkg.sv
sdp_rdma_ig_ctrl.sv
sdp_rdma_cube_walk.sv
sdp_rdma_addr_gen.sv
sdp_rdma_size_calc.sv
sdp_rdma_stall_cnt.sv
sdp_rdma_ig.sv
sdp_rdma_ig_asserts.sv
tb_sdp_rdma_ig.sv

// ==== sdp_rdma_addr_gen.sv ====
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_addr_gen (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          op_load,
  input  logic                          accept,
  input  sdp_rdma_cfg_pkg::walk_flags_t flags,
  input  sdp_rdma_cfg_pkg::rdma_cfg_t   cfg,
  output sdp_rdma_req_pkg::byte_addr_t  req_addr
);

  import sdp_rdma_cfg_pkg::*;
  import sdp_rdma_req_pkg::*;

  granule_addr_t base_addr_line;
  granule_addr_t base_addr_surf;
  granule_addr_t next_surf;

  // start of the following surface
  // carry out is dropped, the address space wraps
  assign next_surf = base_addr_surf + cfg.surf_stride;

  // ========================================
  // line base
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
    end else if (op_load) begin
      base_addr_line <= cfg.base_addr;
    end else if (accept) begin
      if (flags.surf_end) begin
        base_addr_line <= next_surf;
      end else begin
        base_addr_line <= base_addr_line + cfg.line_stride;
      end
    end
  end

  // surface base, moves only at surface end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_surf <= '0;
    end else if (op_load) begin
      base_addr_surf <= cfg.base_addr;
    end else if (accept && flags.surf_end) begin
      base_addr_surf <= next_surf;
    end
  end

  // granule to byte address
  assign req_addr = byte_addr_t'(base_addr_line) << `SDP_ATOM_SHIFT;

endmodule

// ==== sdp_rdma_cfg_pkg.sv ====
`include "sdp_rdma_macros.svh"

package sdp_rdma_cfg_pkg;

  // 0 is int8, 1 is int16
  typedef logic [1:0] precision_t;
  // cube dimension minus one
  typedef logic [`SDP_DIM_W-1:0] dim_t;
  // channel surfaces, 8 channels per surface at int8
  typedef logic [`SDP_DIM_W-3:0] surf_cnt_t;
  // address in 8-byte granules
  typedef logic [`SDP_ADDR_W-`SDP_ATOM_SHIFT-1:0] granule_addr_t;

  // register view seen by the ingress side
  typedef struct packed {
    granule_addr_t base_addr;
    granule_addr_t line_stride;
    granule_addr_t surf_stride;
    dim_t          channel;
    dim_t          height;
    dim_t          width;
    precision_t    precision;
    logic          data_mode;   // 0 per kernel
    logic          data_size;   // 0 one byte
    logic [1:0]    data_use;    // 2 both
  } rdma_cfg_t;

  // walk position seen by ctrl and addr_gen
  typedef struct packed {
    logic surf_end;
    logic cube_end;
  } walk_flags_t;

  typedef enum logic {
    IG_IDLE,
    IG_BUSY
  } ig_state_e;

  // number of surfaces minus one
  // int8 packs 8 channels, everything else 4
  function automatic surf_cnt_t surf_count(input rdma_cfg_t cfg);
    if (cfg.precision == 2'd0) begin
      return surf_cnt_t'(cfg.channel >> 3);
    end
    return surf_cnt_t'(cfg.channel >> 2);
  endfunction

  // per-kernel or 1x1 pack, both issue one request for the whole op
  function automatic logic single_req(input rdma_cfg_t cfg);
    logic pack_1x1;
    pack_1x1 = (cfg.width == '0) && (cfg.height == '0);
    return pack_1x1 || (cfg.data_mode == 1'b0);
  endfunction

endpackage

// ==== sdp_rdma_cube_walk.sv ====
`timescale 1ns/1ps

module sdp_rdma_cube_walk (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          accept,
  input  sdp_rdma_cfg_pkg::rdma_cfg_t   cfg,
  output sdp_rdma_cfg_pkg::walk_flags_t flags
);

  import sdp_rdma_cfg_pkg::*;

  surf_cnt_t size_of_surf;
  surf_cnt_t count_c;
  dim_t      count_h;
  logic      single;
  logic      is_last_h;
  logic      is_last_c;
  logic      is_surf_end;
  logic      is_cube_end;

  // ========================================
  // cube shape
  // ========================================
  assign size_of_surf = surf_count(cfg);
  assign single       = single_req(cfg);

  assign is_last_h = (count_h == cfg.height);
  assign is_last_c = (count_c == size_of_surf);

  // every request is one full line, so the line end is implied
  // single-request modes finish surface and cube at once
  assign is_surf_end = single | is_last_h;
  assign is_cube_end = single | (is_surf_end & is_last_c);

  assign flags.surf_end = is_surf_end;
  assign flags.cube_end = is_cube_end;

  // ========================================
  // channel count across surfaces
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (accept) begin
      if (is_cube_end) begin
        count_c <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // ========================================
  // height count inside a surface
  // ========================================
  // wraps at surface end, which also covers cube end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (accept) begin
      if (is_surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

endmodule

// ==== sdp_rdma_ig.sv ====
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_ig (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           op_load,
  input  sdp_rdma_cfg_pkg::rdma_cfg_t    reg_cfg,
  input  logic                           op_en,
  input  logic                           perf_dma_en,
  input  logic                           dma_rd_req_rdy,
  input  logic                           cq_prdy,
  output sdp_rdma_req_pkg::dma_rd_req_t  dma_rd_req_pd,
  output logic                           dma_rd_req_vld,
  output sdp_rdma_req_pkg::cq_entry_t    cq_pd,
  output logic                           cq_pvld,
  output logic [`SDP_STALL_W-1:0]        rdma_stall
);

  import sdp_rdma_cfg_pkg::*;
  import sdp_rdma_req_pkg::*;

  logic        busy;
  logic        accept;
  walk_flags_t flags;
  byte_addr_t  req_addr;
  req_size_t   req_size;

  // ========================================
  // control
  // ========================================
  sdp_rdma_ig_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cq_prdy         (cq_prdy),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .flags           (flags),
    .busy            (busy),
    .accept          (accept),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .cq_pvld         (cq_pvld)
  );

  // surface and line walk
  sdp_rdma_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .accept          (accept),
    .cfg             (reg_cfg),
    .flags           (flags)
  );

  // ========================================
  // request datapath
  // ========================================
  sdp_rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .accept          (accept),
    .flags           (flags),
    .cfg             (reg_cfg),
    .req_addr        (req_addr)
  );

  sdp_rdma_size_calc u_size_calc (
    .cfg      (reg_cfg),
    .req_size (req_size)
  );

  // dma read and cq entry carry the same size
  assign dma_rd_req_pd.addr = req_addr;
  assign dma_rd_req_pd.size = req_size;
  assign cq_pd.size         = req_size;
  assign cq_pd.cube_end     = flags.cube_end;

  // perf, counts cycles the dma holds off a valid request
  sdp_rdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .enable          (op_en & perf_dma_en),
    .stall           (dma_rd_req_vld & ~dma_rd_req_rdy),
    .count           (rdma_stall)
  );

endmodule

// ==== sdp_rdma_ig_asserts.sv ====
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_ig_asserts (
  input logic                          nvdla_core_clk,
  input logic                          nvdla_core_rstn,
  input logic                          op_load,
  input sdp_rdma_cfg_pkg::rdma_cfg_t   reg_cfg,
  input logic                          op_en,
  input logic                          perf_dma_en,
  input logic                          dma_rd_req_rdy,
  input logic                          cq_prdy,
  input sdp_rdma_req_pkg::dma_rd_req_t dma_rd_req_pd,
  input logic                          dma_rd_req_vld,
  input sdp_rdma_req_pkg::cq_entry_t   cq_pd,
  input logic                          cq_pvld,
  input logic [`SDP_STALL_W-1:0]       rdma_stall
);

  import sdp_rdma_cfg_pkg::*;
  import sdp_rdma_req_pkg::*;

  int                      err_count = 0;
  rdma_cfg_t               op_cfg;
  int                      m_h;
  int                      m_c;
  int                      n_surf;
  int                      e_bytes;
  logic                    m_single;
  logic                    m_last;
  logic                    dma_take;
  logic                    cq_take;
  logic                    stalled;
  granule_addr_t           m_line;
  granule_addr_t           m_surf;
  req_size_t               m_size;
  logic [`SDP_STALL_W-1:0] m_stall;

  // ========================================
  // expected request from the op config
  // ========================================
  always_comb begin
    // surfaces minus one, int8 packs 8 channels, int16 packs 4
    if (op_cfg.precision == 2'd0) begin
      n_surf = int'(op_cfg.channel) / 8;
    end else begin
      n_surf = int'(op_cfg.channel) / 4;
    end
    m_single = !op_cfg.data_mode || (op_cfg.width == '0 && op_cfg.height == '0);
    // bytes per element, doubled for both and for 2-byte int8
    e_bytes = (op_cfg.data_use == 2'd2) ? 2 : 1;
    if (op_cfg.precision == 2'd0 && op_cfg.data_size) begin
      e_bytes = e_bytes * 2;
    end
    if (m_single) begin
      m_size = req_size_t'(n_surf * e_bytes + e_bytes - 1);
    end else begin
      m_size = req_size_t'(int'(op_cfg.width) * e_bytes + e_bytes - 1);
    end
    m_last = m_single || (m_h == int'(op_cfg.height) && m_c == n_surf);
  end

  assign dma_take = dma_rd_req_vld & dma_rd_req_rdy;
  assign cq_take  = cq_pvld & cq_prdy;
  // a valid side held off by its ready
  assign stalled  = (dma_rd_req_vld & ~dma_rd_req_rdy) | (cq_pvld & ~cq_prdy);

  // walk position and line / surface bases
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_cfg <= '0;
      m_h    <= 0;
      m_c    <= 0;
      m_line <= '0;
      m_surf <= '0;
    end else if (op_load) begin
      op_cfg <= reg_cfg;
      m_h    <= 0;
      m_c    <= 0;
      m_line <= reg_cfg.base_addr;
      m_surf <= reg_cfg.base_addr;
    end else if (dma_take) begin
      if (m_single || m_h == int'(op_cfg.height)) begin
        // next surface, or back to the start after the cube
        m_h    <= 0;
        m_c    <= m_last ? 0 : m_c + 1;
        m_line <= m_surf + op_cfg.surf_stride;
        m_surf <= m_surf + op_cfg.surf_stride;
      end else begin
        m_h    <= m_h + 1;
        m_line <= m_line + op_cfg.line_stride;
      end
    end
  end

  // stall cycles since op_load, frozen while perf is off
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      m_stall <= '0;
    end else if (op_en && perf_dma_en) begin
      if (op_load) begin
        m_stall <= '0;
      end else if (dma_rd_req_vld && !dma_rd_req_rdy) begin
        m_stall <= m_stall + 1'b1;
      end
    end
  end

  // ========================================
  // checks
  // ========================================
  a_reset: assert property (@(posedge nvdla_core_clk)
    !nvdla_core_rstn |-> !dma_rd_req_vld && !cq_pvld && rdma_stall == '0)
    else begin
      $error("error dma_rd_req_vld %h cq_pvld %h rdma_stall %h in reset",
             dma_rd_req_vld, cq_pvld, rdma_stall);
      err_count++;
    end

  a_join: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_take == cq_take)
    else begin
      $error("dma request and context queue entry were taken in different cycles");
      err_count++;
    end

  a_addr: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rd_req_vld |-> dma_rd_req_pd.addr == {m_line, {`SDP_ATOM_SHIFT{1'b0}}})
    else begin
      $error("error dma_rd_req_pd.addr %h expected %h", dma_rd_req_pd.addr,
             {m_line, {`SDP_ATOM_SHIFT{1'b0}}});
      err_count++;
    end

  // both payloads carry the table size
  a_size: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rd_req_vld |-> dma_rd_req_pd.size == m_size && cq_pd.size == m_size)
    else begin
      $error("error dma_rd_req_pd.size %h cq_pd.size %h expected %h",
             dma_rd_req_pd.size, cq_pd.size, m_size);
      err_count++;
    end

  a_cube_end: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cq_pvld |-> cq_pd.cube_end == m_last)
    else begin
      $error("error cq_pd.cube_end %h expected %h", cq_pd.cube_end, m_last);
      err_count++;
    end

  a_op_end: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_take && m_last |=> !dma_rd_req_vld && !cq_pvld)
    else begin
      $error("a valid stayed high one cycle after the last request of the cube");
      err_count++;
    end

  a_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    stalled |=> $stable(dma_rd_req_pd) && $stable(cq_pd))
    else begin
      $error("the payload changed while the request was held off");
      err_count++;
    end

  a_stall: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rdma_stall == m_stall)
    else begin
      $error("error rdma_stall %h expected %h", rdma_stall, m_stall);
      err_count++;
    end

endmodule

// ==== sdp_rdma_ig_ctrl.sv ====
`timescale 1ns/1ps

module sdp_rdma_ig_ctrl (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         op_load,
  input  logic                         cq_prdy,
  input  logic                         dma_rd_req_rdy,
  input  sdp_rdma_cfg_pkg::walk_flags_t flags,
  output logic                         busy,
  output logic                         accept,
  output logic                         dma_rd_req_vld,
  output logic                         cq_pvld
);

  import sdp_rdma_cfg_pkg::*;

  ig_state_e state;
  logic      op_done;

  // ========================================
  // busy / idle
  // ========================================
  // last step of the cube ends the op
  assign op_done = accept & flags.cube_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= IG_IDLE;
    end else begin
      case (state)
        IG_IDLE: begin
          if (op_load) begin
            state <= IG_BUSY;
          end
        end
        IG_BUSY: begin
          // a fresh load wins over the done
          if (op_done && !op_load) begin
            state <= IG_IDLE;
          end
        end
        default: state <= IG_IDLE;
      endcase
    end
  end

  assign busy = (state == IG_BUSY);

  // ========================================
  // join of dma and context queue
  // ========================================
  // each valid is clamped by the other side's ready
  assign dma_rd_req_vld = busy & cq_prdy;
  assign cq_pvld        = busy & dma_rd_req_rdy;

  // both sides step in the same cycle
  assign accept = dma_rd_req_vld & dma_rd_req_rdy;

endmodule

// ==== sdp_rdma_macros.svh ====
`ifndef SDP_RDMA_MACROS_SVH
`define SDP_RDMA_MACROS_SVH

// ========================================
// sdp rdma ingress widths
// ========================================

// log2 of the 8-byte address granule
`define SDP_ATOM_SHIFT 3

// full byte address on the dma read bus
`define SDP_ADDR_W 32

// request size, in 32-byte atoms minus one
`define SDP_SIZE_W 15

// channel, height and width fields
`define SDP_DIM_W 13

// perf counter width
`define SDP_STALL_W 32

`endif

// ==== sdp_rdma_req_pkg.sv ====
`include "sdp_rdma_macros.svh"

package sdp_rdma_req_pkg;

  // size in 32-byte atoms minus one
  typedef logic [`SDP_SIZE_W-1:0] req_size_t;
  // byte address
  typedef logic [`SDP_ADDR_W-1:0] byte_addr_t;

  // ========================================
  // dma read request, 47 bits
  // ========================================
  // size sits above the address
  typedef struct packed {
    req_size_t  size;
    byte_addr_t addr;
  } dma_rd_req_t;

  // ========================================
  // context queue entry, 16 bits
  // ========================================
  // egress side uses cube_end to close the op
  typedef struct packed {
    logic      cube_end;
    req_size_t size;
  } cq_entry_t;

endpackage

// ==== sdp_rdma_size_calc.sv ====
`timescale 1ns/1ps

module sdp_rdma_size_calc (
  input  sdp_rdma_cfg_pkg::rdma_cfg_t  cfg,
  output sdp_rdma_req_pkg::req_size_t  req_size
);

  import sdp_rdma_cfg_pkg::*;
  import sdp_rdma_req_pkg::*;

  logic       int8;
  logic       both;
  logic       one_byte;
  logic       illegal;
  logic [1:0] e_shift;
  req_size_t  n_surf;
  req_size_t  n_width;
  req_size_t  size_of_straight;
  req_size_t  size_of_width;

  // n elements of 2**sh bytes, as atoms minus one
  function automatic req_size_t scale(input req_size_t n, input logic [1:0] sh);
    req_size_t ones;
    ones = req_size_t'((1 << sh) - 1);
    return (n << sh) + ones;
  endfunction

  assign int8     = (cfg.precision == 2'd0);
  assign both     = (cfg.data_use == 2'd2);
  assign one_byte = (cfg.data_size == 1'b0);

  // int16 has no 1-byte data
  assign illegal = !int8 && one_byte;

  assign n_surf  = req_size_t'(surf_count(cfg));
  assign n_width = req_size_t'(cfg.width);

  // ========================================
  // bytes per element, as a shift
  // ========================================
  // int8  1B single 1, 2B single 2
  // int8  1B both   2, 2B both   4
  // int16 2B single 1, 2B both   2
  // (int16 counts 2-byte units)
  always_comb begin
    if (int8) begin
      if (both) begin
        e_shift = one_byte ? 2'd1 : 2'd2;
      end else begin
        e_shift = one_byte ? 2'd0 : 2'd1;
      end
    end else begin
      e_shift = both ? 2'd1 : 2'd0;
    end
  end

  // ========================================
  // straight and width sizes
  // ========================================
  // whole channel stack in one request
  // illegal int16 1-byte gives surf doubled, no fill
  always_comb begin
    if (illegal) begin
      size_of_straight = n_surf << 1;
    end else begin
      size_of_straight = scale(n_surf, e_shift);
    end
  end

  // one line of the surface
  assign size_of_width = scale(n_width, e_shift);

  // single-request modes send the straight size
  assign req_size = single_req(cfg) ? size_of_straight : size_of_width;

endmodule

// ==== sdp_rdma_stall_cnt.sv ====
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_stall_cnt (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    op_load,
  input  logic                    enable,
  input  logic                    stall,
  output logic [`SDP_STALL_W-1:0] count
);

  logic [`SDP_STALL_W-1:0] cnt_cur;

  // ========================================
  // dma back-pressure counter
  // ========================================
  // frozen while perf counting is off
  // op_load restarts the count for the new op
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_cur <= '0;
    end else if (enable) begin
      if (op_load) begin
        cnt_cur <= '0;
      end else if (stall) begin
        cnt_cur <= cnt_cur + 1'b1;
      end
    end
  end

  // register value goes straight out
  assign count = cnt_cur;

endmodule

// ==== tb_sdp_rdma_ig.sv ====
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module tb_sdp_rdma_ig;

  import sdp_rdma_cfg_pkg::*;
  import sdp_rdma_req_pkg::*;

  // 12 ops, up to 64 steps each, 8 cycles per step worst case
  localparam int TIMEOUT_CYCLES = 12 * 64 * 8 + 200;

  logic                    nvdla_core_clk;
  logic                    nvdla_core_rstn;
  logic                    op_load;
  rdma_cfg_t               reg_cfg;
  logic                    op_en;
  logic                    perf_dma_en;
  logic                    dma_rd_req_rdy;
  logic                    cq_prdy;
  dma_rd_req_t             dma_rd_req_pd;
  logic                    dma_rd_req_vld;
  cq_entry_t               cq_pd;
  logic                    cq_pvld;
  logic [`SDP_STALL_W-1:0] rdma_stall;

  int seed;
  int cfg_seed;
  int cycles;
  int errs;

  sdp_rdma_ig DUT (.*);

  // stream checker sits inside the DUT
  bind sdp_rdma_ig sdp_rdma_ig_asserts u_asserts (.*);

  // ========================================
  // clock and run limit
  // ========================================
  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge nvdla_core_clk);
      cycles++;
    end
    $display("timeout, the ops did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // random back-pressure on both destinations
  initial begin
    seed           = 32'h869c18ca;
    dma_rd_req_rdy = 1'b0;
    cq_prdy        = 1'b0;
    @(posedge nvdla_core_rstn);
    forever begin
      @(posedge nvdla_core_clk);
      #2;
      dma_rd_req_rdy = ($random(seed) & 3) != 0;
      cq_prdy        = ($random(seed) & 3) != 0;
    end
  end

  // load one op and wait for the cube to finish
  task automatic run_op(input logic [1:0] prec, input logic dsize, input logic [1:0] duse,
                        input logic dmode, input int ch, input int ht, input int wd,
                        input logic en, input logic perf);
    @(posedge nvdla_core_clk);
    #2;
    reg_cfg.base_addr   = granule_addr_t'($random(cfg_seed));
    reg_cfg.line_stride = granule_addr_t'($random(cfg_seed));
    reg_cfg.surf_stride = granule_addr_t'($random(cfg_seed));
    reg_cfg.channel     = dim_t'(ch);
    reg_cfg.height      = dim_t'(ht);
    reg_cfg.width       = dim_t'(wd);
    reg_cfg.precision   = prec;
    reg_cfg.data_mode   = dmode;
    reg_cfg.data_size   = dsize;
    reg_cfg.data_use    = duse;
    op_en               = en;
    perf_dma_en         = perf;
    op_load             = 1'b1;
    @(posedge nvdla_core_clk);
    #2;
    op_load = 1'b0;
    // busy rose on the load edge
    while (DUT.busy) begin
      @(posedge nvdla_core_clk);
      #2;
    end
  endtask

  // ========================================
  // op sequence
  // ========================================
  initial begin
    cfg_seed        = ~32'h869c18ca;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    reg_cfg         = '0;
    op_en           = 1'b0;
    perf_dma_en     = 1'b0;
    repeat (8) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;
    // per element, int8 then int16 over legal sizes and uses
    run_op(2'd0, 1'b0, 2'd0, 1'b1, 31, 7, 15, 1'b1, 1'b1);
    run_op(2'd0, 1'b1, 2'd1, 1'b1, 15, 3, 20, 1'b1, 1'b1);
    run_op(2'd0, 1'b0, 2'd2, 1'b1, 63, 7, 9, 1'b1, 1'b1);
    run_op(2'd0, 1'b1, 2'd2, 1'b1, 7, 12, 30, 1'b1, 1'b1);
    run_op(2'd1, 1'b1, 2'd0, 1'b1, 15, 5, 4, 1'b1, 1'b1);
    run_op(2'd1, 1'b1, 2'd2, 1'b1, 31, 6, 11, 1'b1, 1'b1);
    // perf counter off, then op disabled
    run_op(2'd0, 1'b0, 2'd1, 1'b1, 23, 4, 0, 1'b1, 1'b0);
    run_op(2'd1, 1'b1, 2'd2, 1'b1, 3, 9, 2, 1'b0, 1'b1);
    run_op(2'd0, 1'b1, 2'd2, 1'b1, 40, 0, 7, 1'b1, 1'b1);
    run_op(2'd1, 1'b1, 2'd1, 1'b1, 60, 2, 3, 1'b1, 1'b1);
    // per kernel, then 1x1 pack
    run_op(2'd0, 1'b0, 2'd2, 1'b0, 127, 7, 7, 1'b1, 1'b1);
    run_op(2'd1, 1'b1, 2'd2, 1'b1, 200, 0, 0, 1'b1, 1'b1);
    repeat (4) @(posedge nvdla_core_clk);
    errs = DUT.u_asserts.err_count;
    $display("run done, %0d assertion errors", errs);
    if (errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
